/* include/vertex_config.svh */
`ifndef VERTEX_CONFIG_SVH
`define VERTEX_CONFIG_SVH

// per-vertex array word
`define VERTEX_WIDTH 32

// byte address into host memory
`define ADDR_WIDTH 32

// vertices per cacheline chunk
`define CACHELINE_WORDS 4

// bytes per array word
`define WORD_BYTES 4

// wide enough to hold 0..CACHELINE_WORDS
`define WORD_COUNT_WIDTH 3

// twice the chunk size, so a whole chunk fits behind a partly drained queue
`define QUEUE_DEPTH 8

`endif

/* logic/graph_pkg.sv */
`include "vertex_config.svh"

package graph_pkg;

	////////////////////////////////////////
	// per-vertex data
	////////////////////////////////////////

	typedef logic [`VERTEX_WIDTH-1:0] vertex_word_t;	// one array entry
	typedef logic [`VERTEX_WIDTH-1:0] vertex_id_t;	// running id, also used for counters

	// one assembled vertex, as handed to the consumer
	typedef struct packed {
		vertex_id_t		id;
		vertex_word_t	in_degree;
		vertex_word_t	out_degree;
		vertex_word_t	edges_idx;
	} vertex_t;

	////////////////////////////////////////
	// job descriptor
	////////////////////////////////////////

	typedef struct packed {
		vertex_word_t				num_vertices;
		logic [`ADDR_WIDTH-1:0]	in_degree_base;	// byte address of word 0
		logic [`ADDR_WIDTH-1:0]	out_degree_base;
		logic [`ADDR_WIDTH-1:0]	edges_idx_base;
	} job_desc_t;

endpackage

/* logic/mem_pkg.sv */
`include "vertex_config.svh"

package mem_pkg;

	typedef logic [`ADDR_WIDTH-1:0] addr_t;
	typedef logic [`WORD_COUNT_WIDTH-1:0] word_count_t;	// valid words in a cacheline

	// which per-vertex array a command or response belongs to
	typedef enum logic [1:0] {
		ARRAY_IN_DEGREE,
		ARRAY_OUT_DEGREE,
		ARRAY_EDGES_IDX
	} array_sel_e;

	////////////////////////////////////////
	// read command, fetcher to memory
	////////////////////////////////////////

	typedef struct packed {
		array_sel_e		array;
		addr_t			address;
		word_count_t	word_count;
	} read_cmd_t;

	////////////////////////////////////////
	// read response, memory to fetcher
	////////////////////////////////////////

	// index 0 holds the word at the command address
	typedef graph_pkg::vertex_word_t [`CACHELINE_WORDS-1:0] cacheline_t;

	typedef struct packed {
		logic			valid;	// one-cycle pulse
		array_sel_e		array;
		word_count_t	word_count;	// echoed from the command
		cacheline_t		data;
	} read_resp_t;

endpackage

/* logic/read_request_fsm.sv */
`timescale 1ns/1ps
`include "vertex_config.svh"

module read_request_fsm (
	input  logic					clock,
	input  logic					rstn,
	input  graph_pkg::job_desc_t	job,
	input  logic					job_req,
	input  logic					read_ack,
	input  mem_pkg::read_resp_t		read_resp,
	input  logic					unpack_busy,
	input  logic					assembler_busy,
	input  logic					queue_almost_full,
	output logic					read_req,
	output mem_pkg::read_cmd_t		read_cmd,
	output logic					job_ack
);

	localparam mem_pkg::addr_t CHUNK_BYTES = mem_pkg::addr_t'(`CACHELINE_WORDS * `WORD_BYTES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_WAIT,
		ST_SIZE,
		ST_SEND_IN,
		ST_SEND_OUT,
		ST_SEND_EDGES,
		ST_DONE
	} state_e;

	state_e state;
	state_e next_send;

	graph_pkg::vertex_word_t remaining;	// vertices not yet requested
	mem_pkg::addr_t offset;	// byte offset of the current chunk
	mem_pkg::word_count_t chunk_count;
	mem_pkg::word_count_t size_next;
	logic [1:0] outstanding;	// at most three commands per chunk
	logic acked;	// ack seen, waiting for it to drop
	logic sending;
	logic sent;
	logic drained;
	logic chunk_ready;
	mem_pkg::array_sel_e cmd_array;
	mem_pkg::addr_t cmd_base;

	assign sending = (state == ST_SEND_IN) || (state == ST_SEND_OUT) || (state == ST_SEND_EDGES);
	assign read_req = sending && !acked;
	assign sent = read_req && read_ack;
	assign job_ack = (state == ST_DONE);

	// nothing in flight and nothing left in the pipeline
	assign drained = (outstanding == 2'd0) && !unpack_busy;
	assign chunk_ready = drained && !queue_almost_full && (remaining != '0);

	assign size_next = (remaining < `CACHELINE_WORDS) ? mem_pkg::word_count_t'(remaining) :
		mem_pkg::word_count_t'(`CACHELINE_WORDS);

	////////////////////////////////////////
	// command fields per send state
	////////////////////////////////////////

	always_comb begin
		cmd_array = mem_pkg::ARRAY_IN_DEGREE;
		cmd_base = job.in_degree_base;
		next_send = ST_SEND_OUT;
		case (state)
			ST_SEND_OUT: begin
				cmd_array = mem_pkg::ARRAY_OUT_DEGREE;
				cmd_base = job.out_degree_base;
				next_send = ST_SEND_EDGES;
			end
			ST_SEND_EDGES: begin
				cmd_array = mem_pkg::ARRAY_EDGES_IDX;
				cmd_base = job.edges_idx_base;
				next_send = ST_WAIT;	// chunk fully requested
			end
			default: ;
		endcase
	end

	always_comb begin
		read_cmd.array = cmd_array;
		read_cmd.address = cmd_base + offset;
		read_cmd.word_count = chunk_count;
	end

	////////////////////////////////////////
	// chunk walker
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
			remaining <= '0;
			offset <= '0;
			chunk_count <= '0;
			acked <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job_req)
						state <= ST_LOAD;
				end
				ST_LOAD: begin
					remaining <= job.num_vertices;
					offset <= '0;
					state <= ST_WAIT;
				end
				ST_WAIT: begin
					if (chunk_ready)
						state <= ST_SIZE;
					else if (drained && !assembler_busy && remaining == '0)
						state <= ST_DONE;
				end
				ST_SIZE: begin
					chunk_count <= size_next;	// tail chunk may be short
					remaining <= remaining - graph_pkg::vertex_word_t'(size_next);
					state <= ST_SEND_IN;
				end
				ST_SEND_IN, ST_SEND_OUT, ST_SEND_EDGES: begin
					if (sent) begin
						acked <= 1'b1;
					end else if (acked && !read_ack) begin
						acked <= 1'b0;
						state <= next_send;
						if (state == ST_SEND_EDGES)
							offset <= offset + CHUNK_BYTES;
					end
				end
				ST_DONE: begin
					if (!job_req)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// commands acknowledged minus responses seen
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= 2'd0;
		end else begin
			case ({sent, read_resp.valid})
				2'b10: outstanding <= outstanding + 2'd1;
				2'b01: outstanding <= outstanding - 2'd1;
				default: ;	// both or neither
			endcase
		end
	end

endmodule

/* logic/cacheline_unpacker.sv */
`timescale 1ns/1ps
`include "vertex_config.svh"

module cacheline_unpacker #(
	parameter mem_pkg::array_sel_e ARRAY = mem_pkg::ARRAY_IN_DEGREE
) (
	input  logic					clock,
	input  logic					rstn,
	input  mem_pkg::read_resp_t		read_resp,
	input  logic					shift,
	output graph_pkg::vertex_word_t	word,
	output logic					holds_words
);

	mem_pkg::cacheline_t data;
	mem_pkg::word_count_t count;	// words still to hand out
	logic load;

	// only responses for this array
	assign load = read_resp.valid && (read_resp.array == ARRAY);

	assign word = data[0];
	assign holds_words = (count != '0);

	////////////////////////////////////////
	// word count
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			count <= '0;
		end else if (load) begin
			count <= read_resp.word_count;
		end else if (shift && holds_words) begin
			count <= count - 1'b1;
		end
	end

	// cacheline, next word moves down to index 0
	always_ff @(posedge clock) begin
		if (load)
			data <= read_resp.data;
		else if (shift && holds_words)
			data <= data >> `VERTEX_WIDTH;
	end

endmodule

/* logic/vertex_assembler.sv */
`timescale 1ns/1ps

module vertex_assembler (
	input  logic					clock,
	input  logic					rstn,
	input  graph_pkg::vertex_word_t	in_degree,
	input  graph_pkg::vertex_word_t	out_degree,
	input  graph_pkg::vertex_word_t	edges_idx,
	input  logic					all_hold_words,
	input  logic					queue_full,
	output logic					shift,
	output graph_pkg::vertex_t		vertex,
	output logic					push,
	output graph_pkg::vertex_id_t	pushed_count,
	output graph_pkg::vertex_id_t	filtered_count,
	output logic					busy
);

	graph_pkg::vertex_id_t next_id;	// keeps running across jobs
	logic keep;

	// take one word from each array once all three have one
	assign shift = all_hold_words && !queue_full;

	// no outgoing edges, nothing for the consumer to do
	assign keep = (out_degree != '0);

	// a kept record still on its way into the queue
	assign busy = push;

	////////////////////////////////////////
	// ids, filter decision, counters
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_id <= '0;
			push <= 1'b0;
			pushed_count <= '0;
			filtered_count <= '0;
		end else begin
			push <= shift && keep;
			if (shift) begin
				next_id <= next_id + 1'b1;
				if (keep)
					pushed_count <= pushed_count + 1'b1;
				else
					filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	// record payload
	always_ff @(posedge clock) begin
		if (shift) begin
			vertex.id <= next_id;
			vertex.in_degree <= in_degree;
			vertex.out_degree <= out_degree;
			vertex.edges_idx <= edges_idx;
		end
	end

endmodule

/* logic/vertex_job_queue.sv */
`timescale 1ns/1ps
`include "vertex_config.svh"

module vertex_job_queue (
	input  logic				clock,
	input  logic				rstn,
	input  logic				push,
	input  graph_pkg::vertex_t	vertex,
	input  logic				vertex_req,
	output logic				vertex_ack,
	output graph_pkg::vertex_t	vertex_out,
	output logic				almost_full,
	output logic				full
);

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam logic [PTR_W:0] DEPTH = (PTR_W+1)'(`QUEUE_DEPTH);
	localparam logic [PTR_W:0] AF_LEVEL = (PTR_W+1)'(`QUEUE_DEPTH - `CACHELINE_WORDS);

	graph_pkg::vertex_t mem [`QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic pop;

	// handshake completes when the consumer lets go of req
	assign pop = vertex_ack && !vertex_req;

	// head stays put while ack is high
	assign vertex_out = mem[rd_ptr];

	// last slot already spoken for by a push in flight
	assign full = (count == DEPTH) || ((count == DEPTH - 1'b1) && push);
	assign almost_full = (count > AF_LEVEL);	// no room for another chunk

	////////////////////////////////////////
	// pointers, fill level, consumer ack
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			vertex_ack <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase

			if (pop)
				vertex_ack <= 1'b0;
			else if (vertex_req && !vertex_ack && count != '0)
				vertex_ack <= 1'b1;
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= vertex;
	end

endmodule

/* logic/vertex_job_control.sv */
`timescale 1ns/1ps

module vertex_job_control (
	input  logic					clock,
	input  logic					rstn,
	input  graph_pkg::job_desc_t	job,
	input  logic					job_req,
	output logic					job_ack,
	output logic					read_req,
	output mem_pkg::read_cmd_t		read_cmd,
	input  logic					read_ack,
	input  mem_pkg::read_resp_t		read_resp,
	input  logic					vertex_req,
	output logic					vertex_ack,
	output graph_pkg::vertex_t		vertex_out,
	output graph_pkg::vertex_id_t	pushed_count,
	output graph_pkg::vertex_id_t	filtered_count
);

	graph_pkg::vertex_word_t in_degree_word;
	graph_pkg::vertex_word_t out_degree_word;
	graph_pkg::vertex_word_t edges_idx_word;
	logic in_degree_holds;
	logic out_degree_holds;
	logic edges_idx_holds;
	logic shift;
	logic push;
	logic assembler_busy;
	logic queue_almost_full;
	logic queue_full;
	graph_pkg::vertex_t vertex;

	////////////////////////////////////////
	// request side
	////////////////////////////////////////

	read_request_fsm u_read_request_fsm (
		.clock				(clock),
		.rstn				(rstn),
		.job				(job),
		.job_req			(job_req),
		.read_ack			(read_ack),
		.read_resp			(read_resp),
		.unpack_busy		(in_degree_holds | out_degree_holds | edges_idx_holds),
		.assembler_busy		(assembler_busy),
		.queue_almost_full	(queue_almost_full),
		.read_req			(read_req),
		.read_cmd			(read_cmd),
		.job_ack			(job_ack)
	);

	// one unpacker per array
	cacheline_unpacker #(.ARRAY(mem_pkg::ARRAY_IN_DEGREE)) u_unpack_in_degree (
		.clock			(clock),
		.rstn			(rstn),
		.read_resp		(read_resp),
		.shift			(shift),
		.word			(in_degree_word),
		.holds_words	(in_degree_holds)
	);

	cacheline_unpacker #(.ARRAY(mem_pkg::ARRAY_OUT_DEGREE)) u_unpack_out_degree (
		.clock			(clock),
		.rstn			(rstn),
		.read_resp		(read_resp),
		.shift			(shift),
		.word			(out_degree_word),
		.holds_words	(out_degree_holds)
	);

	cacheline_unpacker #(.ARRAY(mem_pkg::ARRAY_EDGES_IDX)) u_unpack_edges_idx (
		.clock			(clock),
		.rstn			(rstn),
		.read_resp		(read_resp),
		.shift			(shift),
		.word			(edges_idx_word),
		.holds_words	(edges_idx_holds)
	);

	////////////////////////////////////////
	// vertex side
	////////////////////////////////////////

	vertex_assembler u_vertex_assembler (
		.clock			(clock),
		.rstn			(rstn),
		.in_degree		(in_degree_word),
		.out_degree		(out_degree_word),
		.edges_idx		(edges_idx_word),
		.all_hold_words	(in_degree_holds & out_degree_holds & edges_idx_holds),
		.queue_full		(queue_full),
		.shift			(shift),
		.vertex			(vertex),
		.push			(push),
		.pushed_count	(pushed_count),
		.filtered_count	(filtered_count),
		.busy			(assembler_busy)
	);

	vertex_job_queue u_vertex_job_queue (
		.clock			(clock),
		.rstn			(rstn),
		.push			(push),
		.vertex			(vertex),
		.vertex_req		(vertex_req),
		.vertex_ack		(vertex_ack),
		.vertex_out		(vertex_out),
		.almost_full	(queue_almost_full),
		.full			(queue_full)
	);

endmodule

/* testbench/tb_vertex_job_control.sv */
`timescale 1ns/1ps
`include "vertex_config.svh"

module tb_vertex_job_control;

	localparam string STIM_FILE = "testbench/stim_vertex_jobs.txt";
	localparam int SEED = 70809;
	localparam int FILL_LIMIT = `QUEUE_DEPTH - `CACHELINE_WORDS;

	logic clock;
	logic rstn;
	graph_pkg::job_desc_t job;
	logic job_req;
	logic job_ack;
	logic read_req;
	mem_pkg::read_cmd_t read_cmd;
	logic read_ack;
	mem_pkg::read_resp_t read_resp;
	logic vertex_req;
	logic vertex_ack;
	graph_pkg::vertex_t vertex_out;
	graph_pkg::vertex_id_t pushed_count;
	graph_pkg::vertex_id_t filtered_count;

	// expected results, built from the stimulus file
	graph_pkg::job_desc_t jobs[$];
	int expected_pushed[$];	// running totals after each job
	int expected_filtered[$];
	graph_pkg::vertex_t expected_vertices[$];
	mem_pkg::read_cmd_t expected_cmds[$];
	int kept_before_chunk[$];	// records pushed by all earlier chunks
	logic [31:0] word_mem [logic [31:0]];	// byte address to array word
	int total_vertices = 0;
	int total_kept = 0;
	bit stim_ok = 1'b0;
	bit stim_loaded = 1'b0;

	mem_pkg::read_resp_t pending_resp[$];
	int pending_due[$];	// cycle at which each response may go out
	int cycle_count = 0;
	int pops = 0;
	int taken = 0;
	int checks = 0;
	int errors = 0;

	vertex_job_control u_vertex_job_control (
		.clock			(clock),
		.rstn			(rstn),
		.job			(job),
		.job_req		(job_req),
		.job_ack		(job_ack),
		.read_req		(read_req),
		.read_cmd		(read_cmd),
		.read_ack		(read_ack),
		.read_resp		(read_resp),
		.vertex_req		(vertex_req),
		.vertex_ack		(vertex_ack),
		.vertex_out		(vertex_out),
		.pushed_count	(pushed_count),
		.filtered_count	(filtered_count)
	);

	initial clock = 1'b0;
	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (rstn && vertex_ack && !vertex_req)
			pops <= pops + 1;	// same condition the queue pops on
	end

	////////////////////////////////////////
	// checking helpers
	////////////////////////////////////////

	task automatic check(input string name, input logic [63:0] actual, input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail: time %0t, %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic expect_idle_outputs();
		check("read_req", read_req, 1'b0);
		check("job_ack", job_ack, 1'b0);
		check("vertex_ack", vertex_ack, 1'b0);
		check("pushed_count", pushed_count, '0);
		check("filtered_count", filtered_count, '0);
	endtask

	task automatic match_command(input mem_pkg::read_cmd_t cmd);
		mem_pkg::read_cmd_t expected;
		int held;
		if (expected_cmds.size() == 0) begin
			errors++;
			$display("Error: read command at time %0t when none was expected", $time);
		end else begin
			expected = expected_cmds.pop_front();
			check("read_cmd.array", cmd.array, expected.array);
			check("read_cmd.address", cmd.address, expected.address);
			check("read_cmd.word_count", cmd.word_count, expected.word_count);
		end
		// a new chunk needs room in the queue
		if (cmd.array == mem_pkg::ARRAY_IN_DEGREE && kept_before_chunk.size() > 0) begin
			held = kept_before_chunk.pop_front() - pops;
			if (held > FILL_LIMIT) begin
				errors++;
				$display("Error: new chunk requested at time %0t with %0d vertices queued",
					$time, held);
			end
		end
	endtask

	////////////////////////////////////////
	// stimulus file
	////////////////////////////////////////

	task automatic next_data_line(input int fd, output string line, output bit found);
		int status;
		found = 1'b0;
		while (!found && !$feof(fd)) begin
			status = $fgets(line, fd);
			if (status != 0 && line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
				found = 1'b1;
		end
	endtask

	task automatic add_chunk_commands(input graph_pkg::job_desc_t desc, input int chunk,
		input int words);
		mem_pkg::read_cmd_t cmd;
		mem_pkg::addr_t offset;
		offset = mem_pkg::addr_t'(chunk * `CACHELINE_WORDS * `WORD_BYTES);
		cmd.word_count = mem_pkg::word_count_t'(words);
		cmd.array = mem_pkg::ARRAY_IN_DEGREE;
		cmd.address = desc.in_degree_base + offset;
		expected_cmds.push_back(cmd);
		cmd.array = mem_pkg::ARRAY_OUT_DEGREE;
		cmd.address = desc.out_degree_base + offset;
		expected_cmds.push_back(cmd);
		cmd.array = mem_pkg::ARRAY_EDGES_IDX;
		cmd.address = desc.edges_idx_base + offset;
		expected_cmds.push_back(cmd);
	endtask

	task automatic load_stimulus();
		int fd;
		int count;
		int next_id;
		int dropped;
		int remaining;
		int chunk;
		int words;
		int chunk_start;
		int kept_ahead;
		string line;
		bit found;
		bit bad;
		logic [31:0] in_base;
		logic [31:0] out_base;
		logic [31:0] edges_base;
		logic [31:0] in_value;
		logic [31:0] out_value;
		logic [31:0] edges_value;
		graph_pkg::job_desc_t desc;
		graph_pkg::vertex_t record;
		next_id = 0;
		dropped = 0;
		bad = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("Error: stimulus file %s could not be opened", STIM_FILE);
		end else begin
			next_data_line(fd, line, found);
			while (found && !bad) begin
				if ($sscanf(line, "%d %h %h %h", count, in_base, out_base, edges_base) != 4) begin
					bad = 1'b1;
				end else begin
					desc.num_vertices = graph_pkg::vertex_word_t'(count);
					desc.in_degree_base = in_base;
					desc.out_degree_base = out_base;
					desc.edges_idx_base = edges_base;
					jobs.push_back(desc);
					for (int k = 0; k < count && !bad; k++) begin
						next_data_line(fd, line, found);
						if (!found || $sscanf(line, "%h %h %h", in_value, out_value,
							edges_value) != 3) begin
							bad = 1'b1;
						end else begin
							word_mem[in_base + 32'(k * `WORD_BYTES)] = in_value;
							word_mem[out_base + 32'(k * `WORD_BYTES)] = out_value;
							word_mem[edges_base + 32'(k * `WORD_BYTES)] = edges_value;
							if (out_value != '0) begin
								record.id = graph_pkg::vertex_id_t'(next_id);
								record.in_degree = in_value;
								record.out_degree = out_value;
								record.edges_idx = edges_value;
								expected_vertices.push_back(record);
							end else begin
								dropped++;	// never reaches the consumer
							end
							next_id++;	// ids keep counting across jobs
						end
					end
					// full chunks first, then the short tail
					remaining = count;
					chunk = 0;
					while (remaining > 0) begin
						words = (remaining < `CACHELINE_WORDS) ? remaining : `CACHELINE_WORDS;
						chunk_start = next_id - count + chunk * `CACHELINE_WORDS;
						kept_ahead = 0;
						foreach (expected_vertices[i])
							if (int'(expected_vertices[i].id) < chunk_start)
								kept_ahead++;
						kept_before_chunk.push_back(kept_ahead);
						add_chunk_commands(desc, chunk, words);
						remaining -= words;
						chunk++;
					end
					total_vertices += count;
					expected_pushed.push_back(expected_vertices.size());
					expected_filtered.push_back(dropped);
					next_data_line(fd, line, found);
				end
			end
			$fclose(fd);
			if (bad) begin
				errors++;
				$display("Error: stimulus file %s has a malformed or missing line", STIM_FILE);
			end
		end
		stim_ok = (fd != 0) && !bad && (jobs.size() > 0);
		if (stim_ok)
			total_kept = expected_vertices.size();
	endtask

	////////////////////////////////////////
	// memory model
	////////////////////////////////////////

	// words past the end of an array still read back as something
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return addr ^ 32'h5a5a_a5a5;
	endfunction

	task automatic queue_response(input mem_pkg::read_cmd_t cmd);
		mem_pkg::read_resp_t resp;
		logic [31:0] addr;
		resp.valid = 1'b1;
		resp.array = cmd.array;
		resp.word_count = cmd.word_count;
		for (int w = 0; w < `CACHELINE_WORDS; w++) begin
			addr = cmd.address + 32'(w * `WORD_BYTES);
			resp.data[w] = word_mem.exists(addr) ? word_mem[addr] : fill_word(addr);
		end
		pending_resp.push_back(resp);
		pending_due.push_back(cycle_count + int'($urandom_range(6, 2)));
	endtask

	initial begin : memory_commands
		mem_pkg::read_cmd_t cmd;
		read_ack = 1'b0;
		forever begin
			@(negedge clock);
			if (read_req) begin
				cmd = read_cmd;
				match_command(cmd);
				repeat ($urandom_range(3, 0)) @(negedge clock);
				read_ack = 1'b1;
				queue_response(cmd);
				do @(negedge clock); while (read_req);
				read_ack = 1'b0;
			end
		end
	end

	// one response per cycle at most, in command order
	initial begin : memory_responses
		read_resp = '0;
		forever begin
			@(negedge clock);
			if (pending_resp.size() > 0 && cycle_count >= pending_due[0]) begin
				read_resp = pending_resp.pop_front();
				void'(pending_due.pop_front());
			end else begin
				read_resp = '0;
			end
		end
	end

	////////////////////////////////////////
	// consumer
	////////////////////////////////////////

	initial begin : consumer
		graph_pkg::vertex_t expected;
		int idle;
		vertex_req = 1'b0;
		wait (stim_loaded && rstn === 1'b1);
		while (taken < total_kept) begin
			// long stalls let the queue fill up
			if (taken == 0)
				idle = 150;
			else if (taken % 3 == 0)
				idle = 30;
			else
				idle = int'($urandom_range(5, 0));
			repeat (idle) @(negedge clock);
			@(negedge clock);
			vertex_req = 1'b1;
			do @(negedge clock); while (!vertex_ack);
			expected = expected_vertices.pop_front();
			check("vertex_out.id", vertex_out.id, expected.id);
			check("vertex_out.in_degree", vertex_out.in_degree, expected.in_degree);
			check("vertex_out.out_degree", vertex_out.out_degree, expected.out_degree);
			check("vertex_out.edges_idx", vertex_out.edges_idx, expected.edges_idx);
			vertex_req = 1'b0;
			do @(negedge clock); while (vertex_ack);
			taken++;
		end
	end

	////////////////////////////////////////
	// job driver and run control
	////////////////////////////////////////

	task automatic run_job(input int index);
		@(negedge clock);
		job = jobs[index];
		job_req = 1'b1;
		do @(negedge clock); while (!job_ack);
		check("pushed_count", pushed_count, expected_pushed[index]);
		check("filtered_count", filtered_count, expected_filtered[index]);
		job_req = 1'b0;
		do @(negedge clock); while (job_ack);
	endtask

	initial begin : watchdog
		wait (stim_loaded);
		repeat (total_vertices * 400 + 2000) @(posedge clock);
		$display("Error: run did not complete within %0d cycles", total_vertices * 400 + 2000);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : main
		rstn = 1'b0;
		job = '0;
		job_req = 1'b0;
		void'($urandom(SEED));
		load_stimulus();
		stim_loaded = 1'b1;

		@(negedge clock);
		expect_idle_outputs();
		@(negedge clock);
		rstn = 1'b1;
		@(negedge clock);
		expect_idle_outputs();

		if (stim_ok) begin
			foreach (jobs[j])
				run_job(j);
			while (taken < total_kept)
				@(negedge clock);
			check("pushed_count", pushed_count, total_kept);
			check("filtered_count", filtered_count, total_vertices - total_kept);
			check("read commands left over", expected_cmds.size(), 0);
			check("read responses left over", pending_resp.size(), 0);
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* testbench/stim_vertex_jobs.txt */
# job line: vertex_count (decimal) in_degree_base out_degree_base edges_idx_base (hex)
# vertex line: in_degree out_degree edges_idx (hex), one line per vertex of the job above
6 00001000 00002000 00003000
00000002 00000003 00000000
00000001 00000002 00000003
00000004 00000000 00000005
00000000 00000001 00000005
00000003 00000004 00000006
00000002 00000002 0000000a
# second job, ids continue from the first
3 00001100 00002100 00003100
00000001 00000000 00000000
00000005 00000007 00000000
00000000 00000000 00000007

/* project.f */
+incdir+include
logic/graph_pkg.sv
logic/mem_pkg.sv
logic/read_request_fsm.sv
logic/cacheline_unpacker.sv
logic/vertex_assembler.sv
logic/vertex_job_queue.sv
logic/vertex_job_control.sv
testbench/tb_vertex_job_control.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = tb_vertex_job_control
FILELIST = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
